// File: design/udp_rx_consts.svh
// 64-bit datapath constants; the UDP header must fill exactly one data word
`ifndef UDP_RX_CONSTS_SVH
`define UDP_RX_CONSTS_SVH

// stream data width in bits
`define UDP_DATA_W 64

// one keep bit per data byte
`define UDP_KEEP_W 8

// UDP header length in bytes, equal to one full word at this width
`define UDP_HDR_BYTES 8

// length fields and byte counters
`define UDP_LEN_W 16

`endif

// File: design/udp_rx_pkg.sv
// shared types for the UDP receive stage; IP options and Ethernet fields are not carried
`default_nettype none

`include "udp_rx_consts.svh"

package udp_rx_pkg;

  // IP header fields, in the order they appear on the wire
  typedef struct packed {
    logic [3:0]  version;
    logic [3:0]  ihl;
    logic [5:0]  dscp;
    logic [1:0]  ecn;
    logic [15:0] length;
    logic [15:0] identification;
    logic [2:0]  flags;
    logic [12:0] fragment_offset;
    logic [7:0]  ttl;
    logic [7:0]  protocol;
    logic [15:0] header_checksum;
    logic [31:0] source_ip;
    logic [31:0] dest_ip;
  } ip_hdr_t;

  // UDP header, host byte order
  typedef struct packed {
    logic [15:0] source_port;
    logic [15:0] dest_port;
    logic [15:0] length;
    logic [15:0] checksum;
  } udp_hdr_t;

  // combined output header
  typedef struct packed {
    ip_hdr_t  ip;
    udp_hdr_t udp;
  } udp_rx_hdr_t;

  // one stream beat, byte 0 in the low bits
  typedef struct packed {
    logic [`UDP_DATA_W-1:0] data;
    logic [`UDP_KEEP_W-1:0] keep;
    logic                   last;
    logic                   user;
  } axis_beat_t;

  typedef enum logic [1:0] {
    PARSE_IDLE,
    PARSE_HEADER,
    PARSE_PAYLOAD
  } parse_state_t;

  typedef enum logic {
    TRIM_PASS,
    TRIM_DRAIN
  } trim_state_t;

endpackage

`default_nettype wire

// File: design/axis_skid_buffer.sv
// two-entry register slice; s_ready is registered so it lags the downstream ready by one cycle
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer (
  input  logic                   clk,
  input  logic                   rst,
  input  udp_rx_pkg::axis_beat_t s,
  input  logic                   s_valid,
  output logic                   s_ready,
  output udp_rx_pkg::axis_beat_t m,
  output logic                   m_valid,
  input  logic                   m_ready
);
  import udp_rx_pkg::*;

  axis_beat_t out_reg, tmp_reg;
  logic       out_valid, out_valid_next;
  logic       tmp_valid, tmp_valid_next;
  logic       ready_reg, ready_early;
  logic       in_to_out, in_to_tmp, tmp_to_out;

  // accept next cycle if the sink drains or nothing is held
  assign ready_early = m_ready || (!tmp_valid && !out_valid);

  always_comb begin
    out_valid_next = out_valid;
    tmp_valid_next = tmp_valid;
    in_to_out      = 1'b0;
    in_to_tmp      = 1'b0;
    tmp_to_out     = 1'b0;
    if (ready_reg) begin
      if (m_ready || !out_valid) begin
        out_valid_next = s_valid;
        in_to_out      = 1'b1;
      end else begin
        // output stalled, park the incoming beat
        tmp_valid_next = s_valid;
        in_to_tmp      = 1'b1;
      end
    end else if (m_ready) begin
      out_valid_next = tmp_valid;
      tmp_valid_next = 1'b0;
      tmp_to_out     = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      tmp_valid <= 1'b0;
      ready_reg <= 1'b0;
    end else begin
      out_valid <= out_valid_next;
      tmp_valid <= tmp_valid_next;
      ready_reg <= ready_early;
    end
  end

  always_ff @(posedge clk) begin
    if (in_to_out) begin
      out_reg <= s;
    end else if (tmp_to_out) begin
      out_reg <= tmp_reg;
    end
    if (in_to_tmp) begin
      tmp_reg <= s;
    end
  end

  assign s_ready = ready_reg;
  assign m       = out_reg;
  assign m_valid = out_valid;

  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    (m_valid && !m_ready) |=> (m_valid && $stable(m)))
    else $error("output beat changed while stalled");

endmodule

`default_nettype wire

// File: design/udp_payload_trim.sv
// keep on each input beat must be contiguous from byte 0; payload_len is read on the first beat
`timescale 1ns/1ps
`default_nettype none

`include "udp_rx_consts.svh"

module udp_payload_trim (
  input  logic                   clk,
  input  logic                   rst,
  input  udp_rx_pkg::axis_beat_t body,
  input  logic                   body_valid,
  output logic                   body_ready,
  input  logic [`UDP_LEN_W-1:0]  payload_len,
  output logic                   frame_done,
  output udp_rx_pkg::axis_beat_t trim_out,
  output logic                   trim_valid,
  input  logic                   trim_ready,
  output logic                   error_payload_early_termination
);
  import udp_rx_pkg::*;

  localparam int CNT_W = $clog2(`UDP_KEEP_W + 1);

  trim_state_t            state;
  logic [`UDP_LEN_W-1:0]  remain_reg;
  logic                   first_reg;
  logic [`UDP_LEN_W-1:0]  rem;
  logic [CNT_W-1:0]       keep_cnt;
  logic [`UDP_KEEP_W-1:0] keep_mask;
  logic [`UDP_KEEP_W-1:0] keep_inc;
  logic                   accept;
  logic                   end_word;
  logic                   short_frame;
  logic                   err_reg;

  function automatic logic [CNT_W-1:0] count_keep(input logic [`UDP_KEEP_W-1:0] k);
    logic [CNT_W-1:0] n;
    n = '0;
    for (int i = 0; i < `UDP_KEEP_W; i++) begin
      if (k[i]) begin
        n = n + 1'b1;
      end
    end
    return n;
  endfunction

  // bytes still owed to the output, counter loads on the first beat
  assign rem      = first_reg ? payload_len : remain_reg;
  assign keep_cnt = count_keep(body.keep);
  assign end_word = rem <= `UDP_LEN_W'(`UDP_KEEP_W);

  // low rem bytes, all bytes when rem equals the word size
  assign keep_mask = ~({`UDP_KEEP_W{1'b1}} << rem[CNT_W-1:0]);
  assign keep_inc  = body.keep + 1'b1;

  // input ended before the UDP length was reached
  assign short_frame = body.last && (`UDP_LEN_W'(keep_cnt) < rem);

  assign body_ready = (state == TRIM_DRAIN) || trim_ready;
  assign accept     = body_valid && body_ready;
  assign frame_done = accept && body.last;

  assign trim_valid    = body_valid && (state == TRIM_PASS);
  assign trim_out.data = body.data;
  assign trim_out.keep = end_word ? (body.keep & keep_mask) : body.keep;
  assign trim_out.last = end_word || body.last;
  assign trim_out.user = body.user || short_frame;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= TRIM_PASS;
      first_reg  <= 1'b1;
      remain_reg <= '0;
      err_reg    <= 1'b0;
    end else begin
      err_reg <= accept && (state == TRIM_PASS) && short_frame;
      if (accept) begin
        if (body.last) begin
          first_reg <= 1'b1;
          state     <= TRIM_PASS;
        end else begin
          first_reg  <= 1'b0;
          remain_reg <= rem - `UDP_LEN_W'(`UDP_KEEP_W);
          // UDP length reached early, discard padding up to input last
          if ((state == TRIM_PASS) && end_word) begin
            state <= TRIM_DRAIN;
          end
        end
      end
    end
  end

  assign error_payload_early_termination = err_reg;

  // upstream must pack bytes from lane 0 upwards
  a_keep_contig: assert property (@(posedge clk) disable iff (rst)
    body_valid |-> ((body.keep & keep_inc) == '0))
    else $error("payload keep not contiguous from byte 0");

endmodule

`default_nettype wire

// File: design/udp_hdr_parse.sv
// first payload word must hold the whole UDP header; UDP lengths below 9 are not supported
`timescale 1ns/1ps
`default_nettype none

`include "udp_rx_consts.svh"

module udp_hdr_parse (
  input  logic                        clk,
  input  logic                        rst,
  input  udp_rx_pkg::ip_hdr_t         s_ip_hdr,
  input  logic                        s_ip_hdr_valid,
  output logic                        s_ip_hdr_ready,
  input  udp_rx_pkg::axis_beat_t      s_ip_payload,
  input  logic                        s_ip_payload_valid,
  output logic                        s_ip_payload_ready,
  output udp_rx_pkg::axis_beat_t      body,
  output logic                        body_valid,
  input  logic                        body_ready,
  output logic [`UDP_LEN_W-1:0]       payload_len,
  input  logic                        frame_done,
  output udp_rx_pkg::udp_rx_hdr_t     m_udp_hdr,
  output logic                        m_udp_hdr_valid,
  input  logic                        m_udp_hdr_ready,
  output logic                        busy,
  output logic                        error_header_early_termination
);
  import udp_rx_pkg::*;

  parse_state_t state, state_next;
  udp_rx_hdr_t  hdr_reg;
  logic         hdr_valid_reg, hdr_valid_next;
  logic         hdr_ready_reg, hdr_ready_next;
  logic         busy_reg;
  logic         err_hdr_reg, err_hdr_next;
  logic         store_ip, store_udp;
  logic         word_xfer;

  // payload ready is always high while waiting for the header word
  assign word_xfer = (state == PARSE_HEADER) && s_ip_payload_valid;

  always_comb begin
    state_next     = state;
    store_ip       = 1'b0;
    store_udp      = 1'b0;
    err_hdr_next   = 1'b0;
    hdr_valid_next = hdr_valid_reg && !m_udp_hdr_ready;
    case (state)
      PARSE_IDLE: begin
        if (s_ip_hdr_valid && hdr_ready_reg) begin
          store_ip   = 1'b1;
          state_next = PARSE_HEADER;
        end
      end
      PARSE_HEADER: begin
        if (word_xfer) begin
          if (s_ip_payload.last) begin
            // frame too short to hold a UDP header, drop it
            err_hdr_next = 1'b1;
            state_next   = PARSE_IDLE;
          end else begin
            store_udp      = 1'b1;
            hdr_valid_next = 1'b1;
            state_next     = PARSE_PAYLOAD;
          end
        end
      end
      PARSE_PAYLOAD: begin
        if (frame_done) begin
          state_next = PARSE_IDLE;
        end
      end
      default: state_next = PARSE_IDLE;
    endcase
    // next header only once the previous one has left
    hdr_ready_next = (state_next == PARSE_IDLE) && !hdr_valid_next;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= PARSE_IDLE;
      hdr_valid_reg <= 1'b0;
      hdr_ready_reg <= 1'b0;
      busy_reg      <= 1'b0;
      err_hdr_reg   <= 1'b0;
    end else begin
      state         <= state_next;
      hdr_valid_reg <= hdr_valid_next;
      hdr_ready_reg <= hdr_ready_next;
      busy_reg      <= state_next != PARSE_IDLE;
      err_hdr_reg   <= err_hdr_next;
    end
  end

  // header fields, network order swapped to host order
  always_ff @(posedge clk) begin
    if (store_ip) begin
      hdr_reg.ip <= s_ip_hdr;
    end
    if (store_udp) begin
      hdr_reg.udp.source_port <= {s_ip_payload.data[7:0], s_ip_payload.data[15:8]};
      hdr_reg.udp.dest_port   <= {s_ip_payload.data[23:16], s_ip_payload.data[31:24]};
      hdr_reg.udp.length      <= {s_ip_payload.data[39:32], s_ip_payload.data[47:40]};
      hdr_reg.udp.checksum    <= {s_ip_payload.data[55:48], s_ip_payload.data[63:56]};
    end
  end

  assign s_ip_hdr_ready     = hdr_ready_reg;
  assign s_ip_payload_ready = (state == PARSE_HEADER) ||
                              ((state == PARSE_PAYLOAD) && body_ready);

  // only words after the UDP header reach the trimmer
  assign body        = s_ip_payload;
  assign body_valid  = (state == PARSE_PAYLOAD) && s_ip_payload_valid;
  assign payload_len = hdr_reg.udp.length - `UDP_LEN_W'(`UDP_HDR_BYTES);

  assign m_udp_hdr                      = hdr_reg;
  assign m_udp_hdr_valid                = hdr_valid_reg;
  assign busy                           = busy_reg;
  assign error_header_early_termination = err_hdr_reg;

  // the trimmer needs at least one payload byte to end a frame
  a_udp_len_min: assert property (@(posedge clk) disable iff (rst)
    (word_xfer && !s_ip_payload.last) |=> (hdr_reg.udp.length >= `UDP_LEN_W'(9)))
    else $error("udp length below 9 not supported");

endmodule

`default_nettype wire

// File: design/udp_ip_rx.sv
// UDP receive top; IP header options are not supported, the payload must start with the UDP header
`timescale 1ns/1ps
`default_nettype none

`include "udp_rx_consts.svh"

module udp_ip_rx (
  input  logic                    clk,
  input  logic                    rst,
  input  udp_rx_pkg::ip_hdr_t     s_ip_hdr,
  input  logic                    s_ip_hdr_valid,
  output logic                    s_ip_hdr_ready,
  input  udp_rx_pkg::axis_beat_t  s_ip_payload,
  input  logic                    s_ip_payload_valid,
  output logic                    s_ip_payload_ready,
  output udp_rx_pkg::udp_rx_hdr_t m_udp_hdr,
  output logic                    m_udp_hdr_valid,
  input  logic                    m_udp_hdr_ready,
  output udp_rx_pkg::axis_beat_t  m_udp_payload,
  output logic                    m_udp_payload_valid,
  input  logic                    m_udp_payload_ready,
  output logic                    busy,
  output logic                    error_header_early_termination,
  output logic                    error_payload_early_termination
);
  import udp_rx_pkg::*;

  axis_beat_t            body;
  logic                  body_valid;
  logic                  body_ready;
  logic [`UDP_LEN_W-1:0] payload_len;
  logic                  frame_done;
  axis_beat_t            trim_out;
  logic                  trim_valid;
  logic                  trim_ready;

  udp_hdr_parse i_udp_hdr_parse (
    .clk                            (clk),
    .rst                            (rst),
    .s_ip_hdr                       (s_ip_hdr),
    .s_ip_hdr_valid                 (s_ip_hdr_valid),
    .s_ip_hdr_ready                 (s_ip_hdr_ready),
    .s_ip_payload                   (s_ip_payload),
    .s_ip_payload_valid             (s_ip_payload_valid),
    .s_ip_payload_ready             (s_ip_payload_ready),
    .body                           (body),
    .body_valid                     (body_valid),
    .body_ready                     (body_ready),
    .payload_len                    (payload_len),
    .frame_done                     (frame_done),
    .m_udp_hdr                      (m_udp_hdr),
    .m_udp_hdr_valid                (m_udp_hdr_valid),
    .m_udp_hdr_ready                (m_udp_hdr_ready),
    .busy                           (busy),
    .error_header_early_termination (error_header_early_termination)
  );

  udp_payload_trim i_udp_payload_trim (
    .clk                             (clk),
    .rst                             (rst),
    .body                            (body),
    .body_valid                      (body_valid),
    .body_ready                      (body_ready),
    .payload_len                     (payload_len),
    .frame_done                      (frame_done),
    .trim_out                        (trim_out),
    .trim_valid                      (trim_valid),
    .trim_ready                      (trim_ready),
    .error_payload_early_termination (error_payload_early_termination)
  );

  axis_skid_buffer i_axis_skid_buffer (
    .clk     (clk),
    .rst     (rst),
    .s       (trim_out),
    .s_valid (trim_valid),
    .s_ready (trim_ready),
    .m       (m_udp_payload),
    .m_valid (m_udp_payload_valid),
    .m_ready (m_udp_payload_ready)
  );

endmodule

`default_nettype wire

// File: dv/udp_ip_rx_tb.sv
// table-driven frames on one 64-bit stream; only the payload sink stalls and the header sink is always ready
`timescale 1ns/1ps
`default_nettype none

`include "udp_rx_consts.svh"

module udp_ip_rx_tb;
  import udp_rx_pkg::*;

  localparam int NUM_ROWS  = 14;
  localparam int MAX_BYTES = 128;

  // UDP length field, bytes sent incl. UDP header and sink stall percent per frame
  typedef struct packed {
    int udp_len;
    int in_bytes;
    int stall_pct;
  } frame_row_t;

  logic        clk;
  logic        rst;
  ip_hdr_t     s_ip_hdr;
  logic        s_ip_hdr_valid;
  logic        s_ip_hdr_ready;
  axis_beat_t  s_ip_payload;
  logic        s_ip_payload_valid;
  logic        s_ip_payload_ready;
  udp_rx_hdr_t m_udp_hdr;
  logic        m_udp_hdr_valid;
  logic        m_udp_hdr_ready;
  axis_beat_t  m_udp_payload;
  logic        m_udp_payload_valid;
  logic        m_udp_payload_ready;
  logic        busy;
  logic        error_header_early_termination;
  logic        error_payload_early_termination;

  frame_row_t  rows [NUM_ROWS];
  logic [7:0]  frame_bytes [0:MAX_BYTES-1];
  int          seed = 36;
  int          stall_pct;
  int          row_idx;
  int          cycle_count;
  int          cycle_limit;

  // expected output filled by the driver and drained by the monitor
  udp_rx_hdr_t exp_hdr_q[$];
  int          exp_hdr_idx_q[$];
  logic [7:0]  exp_byte_q[$];
  int          exp_len_q[$];
  logic        exp_user_q[$];
  int          exp_frame_q[$];
  int          exp_hdr_err;
  int          exp_pay_err;
  int          hdr_err_seen;
  int          pay_err_seen;
  int          hdr_seen;
  int          out_cnt;

  udp_ip_rx i_udp_ip_rx (
    .clk                             (clk),
    .rst                             (rst),
    .s_ip_hdr                        (s_ip_hdr),
    .s_ip_hdr_valid                  (s_ip_hdr_valid),
    .s_ip_hdr_ready                  (s_ip_hdr_ready),
    .s_ip_payload                    (s_ip_payload),
    .s_ip_payload_valid              (s_ip_payload_valid),
    .s_ip_payload_ready              (s_ip_payload_ready),
    .m_udp_hdr                       (m_udp_hdr),
    .m_udp_hdr_valid                 (m_udp_hdr_valid),
    .m_udp_hdr_ready                 (m_udp_hdr_ready),
    .m_udp_payload                   (m_udp_payload),
    .m_udp_payload_valid             (m_udp_payload_valid),
    .m_udp_payload_ready             (m_udp_payload_ready),
    .busy                            (busy),
    .error_header_early_termination  (error_header_early_termination),
    .error_payload_early_termination (error_payload_early_termination)
  );

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  // builds one frame and records what must come out before driving it
  task automatic send_frame(input int idx, input frame_row_t row);
    ip_hdr_t     ip;
    udp_rx_hdr_t hdr;
    axis_beat_t  beat;
    logic [15:0] sport;
    logic [15:0] dport;
    logic [15:0] csum;
    logic [15:0] ulen;
    int          nwords;
    int          out_len;
    nwords = (row.in_bytes + 7) / 8;
    sport  = 16'h1000 + 16'(idx);
    dport  = 16'h2000 + 16'(idx);
    csum   = 16'hc000 + 16'(idx);
    ulen   = 16'(row.udp_len);
    ip.version         = 4'd4;
    ip.ihl             = 4'd5;
    ip.dscp            = 6'(idx);
    ip.ecn             = 2'd0;
    ip.length          = 16'(20 + row.in_bytes);
    ip.identification  = 16'h0100 + 16'(idx);
    ip.flags           = 3'b010;
    ip.fragment_offset = 13'd0;
    ip.ttl             = 8'd64;
    ip.protocol        = 8'd17;
    ip.header_checksum = 16'hbeef ^ 16'(idx);
    ip.source_ip       = 32'hc0a80001 + 32'(idx);
    ip.dest_ip         = 32'hc0a80100 + 32'(idx);
    // UDP header in network order followed by the byte pattern
    frame_bytes[0] = sport[15:8];
    frame_bytes[1] = sport[7:0];
    frame_bytes[2] = dport[15:8];
    frame_bytes[3] = dport[7:0];
    frame_bytes[4] = ulen[15:8];
    frame_bytes[5] = ulen[7:0];
    frame_bytes[6] = csum[15:8];
    frame_bytes[7] = csum[7:0];
    for (int b = `UDP_HDR_BYTES; b < MAX_BYTES; b++) begin
      frame_bytes[b] = 8'(idx + b);
    end
    if (row.in_bytes > `UDP_HDR_BYTES) begin
      hdr.ip              = ip;
      hdr.udp.source_port = sport;
      hdr.udp.dest_port   = dport;
      hdr.udp.length      = ulen;
      hdr.udp.checksum    = csum;
      exp_hdr_q.push_back(hdr);
      exp_hdr_idx_q.push_back(idx);
      // output stops at the UDP length or at the end of input if that comes first
      out_len = (row.udp_len < row.in_bytes ? row.udp_len : row.in_bytes) - `UDP_HDR_BYTES;
      for (int b = `UDP_HDR_BYTES; b < `UDP_HDR_BYTES + out_len; b++) begin
        exp_byte_q.push_back(frame_bytes[b]);
      end
      exp_len_q.push_back(out_len);
      exp_user_q.push_back(row.in_bytes < row.udp_len);
      exp_frame_q.push_back(idx);
      if (row.in_bytes < row.udp_len) begin
        exp_pay_err++;
      end
    end else begin
      exp_hdr_err++;
    end
    assert (!busy) else fail_run($sformatf("busy still high before frame %0d started", idx));
    s_ip_hdr       = ip;
    s_ip_hdr_valid = 1'b1;
    while (!s_ip_hdr_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    s_ip_hdr_valid = 1'b0;
    for (int w = 0; w < nwords; w++) begin
      beat = '0;
      for (int j = 0; j < `UDP_KEEP_W; j++) begin
        if (8 * w + j < row.in_bytes) begin
          beat.data[8*j +: 8] = frame_bytes[8 * w + j];
          beat.keep[j]        = 1'b1;
        end
      end
      beat.last          = (w == nwords - 1);
      s_ip_payload       = beat;
      s_ip_payload_valid = 1'b1;
      while (!s_ip_payload_ready) begin
        @(negedge clk);
      end
      assert (busy) else fail_run($sformatf("busy low during frame %0d word %0d", idx, w));
      @(negedge clk);
    end
    s_ip_payload_valid = 1'b0;
  endtask

  task automatic check_header();
    assert (exp_hdr_q.size() > 0) else fail_run("output header appeared with no frame expecting one");
    assert (m_udp_hdr == exp_hdr_q[0])
      else fail_run($sformatf("mismatch frame %0d header: expected %h, actual %h",
                              exp_hdr_idx_q[0], exp_hdr_q[0], m_udp_hdr));
    void'(exp_hdr_q.pop_front());
    void'(exp_hdr_idx_q.pop_front());
    hdr_seen++;
  endtask

  task automatic check_beat();
    logic [7:0] exp_b;
    assert (exp_len_q.size() > 0) else fail_run("payload beat appeared with no frame expecting one");
    for (int j = 0; j < `UDP_KEEP_W; j++) begin
      if (m_udp_payload.keep[j]) begin
        assert (out_cnt < exp_len_q[0])
          else fail_run($sformatf("frame %0d put out more than %0d bytes",
                                  exp_frame_q[0], exp_len_q[0]));
        exp_b = exp_byte_q.pop_front();
        assert (m_udp_payload.data[8*j +: 8] == exp_b)
          else fail_run($sformatf("mismatch frame %0d byte %0d: expected %h, actual %h",
                                  exp_frame_q[0], out_cnt, exp_b, m_udp_payload.data[8*j +: 8]));
        out_cnt++;
      end
    end
    if (m_udp_payload.last) begin
      assert (out_cnt == exp_len_q[0])
        else fail_run($sformatf("mismatch frame %0d length: expected %0d, actual %0d",
                                exp_frame_q[0], exp_len_q[0], out_cnt));
      assert (m_udp_payload.user == exp_user_q[0])
        else fail_run($sformatf("mismatch frame %0d user: expected %0b, actual %0b",
                                exp_frame_q[0], exp_user_q[0], m_udp_payload.user));
      void'(exp_len_q.pop_front());
      void'(exp_user_q.pop_front());
      void'(exp_frame_q.pop_front());
      out_cnt = 0;
    end else begin
      assert (!m_udp_payload.user)
        else fail_run($sformatf("mismatch frame %0d user before last: expected 0, actual 1",
                                exp_frame_q[0]));
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // payload sink with random stalls
  initial begin
    m_udp_payload_ready = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst) begin
        m_udp_payload_ready = ($unsigned($random(seed)) % 100) >= stall_pct;
      end
    end
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        fail_run($sformatf("timeout after %0d cycles with frames still in flight", cycle_limit));
      end
    end
  end

  // values seen here are the ones before the edge
  always @(posedge clk) begin
    if (!rst) begin
      if (error_header_early_termination) begin
        hdr_err_seen++;
      end
      if (error_payload_early_termination) begin
        pay_err_seen++;
      end
      if (m_udp_hdr_valid && m_udp_hdr_ready) begin
        check_header();
      end
      if (m_udp_payload_valid && m_udp_payload_ready) begin
        check_beat();
      end
    end
  end

  initial begin
    rows[0]  = '{32, 32, 0};
    rows[1]  = '{21, 21, 0};
    rows[2]  = '{20, 40, 30};
    rows[3]  = '{13, 48, 0};
    rows[4]  = '{40, 27, 20};
    rows[5]  = '{20, 18, 0};
    rows[6]  = '{16, 6, 0};
    rows[7]  = '{24, 24, 0};
    rows[8]  = '{64, 64, 50};
    rows[9]  = '{9, 9, 50};
    rows[10] = '{50, 30, 40};
    rows[11] = '{16, 8, 0};
    rows[12] = '{100, 100, 50};
    rows[13] = '{17, 24, 40};
    cycle_limit = 50;
    for (row_idx = 0; row_idx < NUM_ROWS; row_idx++) begin
      cycle_limit += 4 * ((rows[row_idx].in_bytes + 7) / 8);
    end
    rst                = 1'b1;
    stall_pct          = 0;
    s_ip_hdr           = '0;
    s_ip_hdr_valid     = 1'b0;
    s_ip_payload       = '0;
    s_ip_payload_valid = 1'b0;
    m_udp_hdr_ready    = 1'b1;
    exp_hdr_err        = 0;
    exp_pay_err        = 0;
    hdr_err_seen       = 0;
    pay_err_seen       = 0;
    hdr_seen           = 0;
    out_cnt            = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    assert (!busy && !s_ip_hdr_ready && !s_ip_payload_ready && !m_udp_hdr_valid &&
            !m_udp_payload_valid && !error_header_early_termination &&
            !error_payload_early_termination)
      else fail_run("an output was not low after reset");
    rst = 1'b0;
    for (row_idx = 0; row_idx < NUM_ROWS; row_idx++) begin
      stall_pct = rows[row_idx].stall_pct;
      send_frame(row_idx, rows[row_idx]);
    end
    // let the last frames drain through the skid buffer
    while (exp_len_q.size() > 0 || busy) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
    assert (hdr_err_seen == exp_hdr_err)
      else fail_run($sformatf("mismatch header early termination count: expected %0d, actual %0d",
                              exp_hdr_err, hdr_err_seen));
    assert (pay_err_seen == exp_pay_err)
      else fail_run($sformatf("mismatch payload early termination count: expected %0d, actual %0d",
                              exp_pay_err, pay_err_seen));
    assert (hdr_seen == NUM_ROWS - exp_hdr_err)
      else fail_run($sformatf("mismatch header count: expected %0d, actual %0d",
                              NUM_ROWS - exp_hdr_err, hdr_seen));
    assert (!busy && !m_udp_hdr_valid && !m_udp_payload_valid)
      else fail_run("busy or a valid output still high after the last frame");
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: udp_ip_rx.f
+incdir+design
design/udp_rx_pkg.sv
design/axis_skid_buffer.sv
design/udp_payload_trim.sv
design/udp_hdr_parse.sv
design/udp_ip_rx.sv
dv/udp_ip_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f udp_ip_rx.f \
  --top-module udp_ip_rx_tb --Mdir obj_dir -o udp_ip_rx_sim

# the simulator status is checked through the log below
obj_dir/udp_ip_rx_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
